//--- lane_deserializer.sv
`timescale 1ns/1ps

module lane_deserializer #(
	parameter int WORD_WIDTH = lvds_rx_link_pkg::word_width_default
) (
	input  logic                  bit_clock,
	input  logic                  arst_n,
	input  logic                  serial_in,   // one bit per bit_clock
	input  logic                  word_strobe, // common framing strobe
	input  logic                  bitslip,     // one-cycle pulse, rotate by one bit
	output logic [WORD_WIDTH-1:0] lane_word,   // bit 0 earliest received
	output logic                  lane_valid   // one cycle after word_strobe
);

	localparam int offset_width = (WORD_WIDTH > 1) ? $clog2(WORD_WIDTH) : 1;

	logic [2*WORD_WIDTH-1:0] window; // newest bit at the top
	logic [2*WORD_WIDTH-1:0] window_next; // window including the bit being sampled
	logic [offset_width-1:0] offset; // bitslip position, 0..WORD_WIDTH-1
	logic [WORD_WIDTH-1:0] word_sel; // word at the current offset

	// the incoming bit enters at the top, older bits move down
	assign window_next = {serial_in, window[2*WORD_WIDTH-1:1]};

	// offset 0 takes the WORD_WIDTH newest bits including serial_in,
	// each step of offset reaches one bit further back in time
	// lowest selected bit is the earliest one, so it lands in bit 0
	assign word_sel = window_next[(2*WORD_WIDTH - 1 - int'(offset)) -: WORD_WIDTH];

	always_ff @(posedge bit_clock) begin
		window <= window_next; // free running, keeps shifting during capture
	end

	// capture register, words overlap with the next shift-in
	always_ff @(posedge bit_clock) begin
		if (word_strobe) begin
			lane_word <= word_sel;
		end
	end

	always_ff @(posedge bit_clock or negedge arst_n) begin
		if (!arst_n) begin
			lane_valid <= 1'b0;
			offset <= '0;
		end else begin
			lane_valid <= word_strobe;
			// slips land well between strobes, so the new offset
			// applies from the next word on
			if (bitslip) begin
				if (offset == offset_width'(WORD_WIDTH - 1)) begin
					offset <= '0; // wrap modulo WORD_WIDTH
				end else begin
					offset <= offset + 1'b1;
				end
			end
		end
	end

endmodule

//--- lane_trainer.sv
`timescale 1ns/1ps

module lane_trainer #(
	parameter int WORD_WIDTH = lvds_rx_link_pkg::word_width_default,
	parameter int N_LANES = lvds_rx_link_pkg::n_lanes_default
) (
	input  logic                          bit_clock,
	input  logic                          arst_n,
	input  logic [N_LANES*WORD_WIDTH-1:0] lane_words,  // lane 0 in the low bits
	input  logic [N_LANES-1:0]            lane_valid,
	input  logic                          retrain,     // one-cycle request
	output logic [N_LANES-1:0]            bitslip,     // one-cycle pulse per lane
	output logic [N_LANES*WORD_WIDTH-1:0] words,
	output logic                          words_valid,
	output logic [N_LANES-1:0]            lane_locked,
	output logic                          link_up
);

	import lvds_rx_link_pkg::*;
	import lvds_rx_train_pkg::*;

	localparam logic [WORD_WIDTH-1:0] train_word = WORD_WIDTH'(training_word);

	train_state_t state [N_LANES]; // one fsm per lane
	logic [match_cnt_width-1:0] match_cnt [N_LANES]; // matches in a row
	logic [settle_cnt_width-1:0] settle_cnt [N_LANES]; // words dropped so far
	logic [N_LANES-1:0] lane_match; // word equals the training word
	logic word_tick; // a word arrives on this cycle
	logic retrain_pend; // retrain seen, waiting for the next word
	logic flush; // apply retrain on this word

	always_comb begin
		for (int i = 0; i < N_LANES; i++) begin
			lane_match[i] = (lane_words[i*WORD_WIDTH +: WORD_WIDTH] == train_word);
		end
	end

	assign word_tick = |lane_valid; // lanes share one strobe
	assign flush = retrain_pend | retrain;

	// output words, no reset on the payload path
	always_ff @(posedge bit_clock) begin
		for (int i = 0; i < N_LANES; i++) begin
			if (lane_valid[i]) begin
				words[i*WORD_WIDTH +: WORD_WIDTH] <= lane_words[i*WORD_WIDTH +: WORD_WIDTH];
			end
		end
	end

	always_ff @(posedge bit_clock or negedge arst_n) begin
		if (!arst_n) begin
			words_valid <= 1'b0;
			bitslip <= '0;
			retrain_pend <= 1'b0;
			for (int i = 0; i < N_LANES; i++) begin
				state[i] <= hunt;
				match_cnt[i] <= '0;
				settle_cnt[i] <= '0;
			end
		end else begin
			words_valid <= word_tick; // every word, locked or not
			bitslip <= '0; // pulses last one cycle

			// hold a retrain until the next word so lock drops with words_valid
			if (word_tick) begin
				retrain_pend <= 1'b0;
			end else if (retrain) begin
				retrain_pend <= 1'b1;
			end

			for (int i = 0; i < N_LANES; i++) begin
				if (lane_valid[i]) begin
					if (flush) begin
						state[i] <= hunt; // start over, word not judged
						match_cnt[i] <= '0;
						settle_cnt[i] <= '0;
					end else begin
						case (state[i])
							hunt: begin
								if (lane_match[i]) begin
									if (match_cnt[i] == match_cnt_width'(lock_matches - 1)) begin
										state[i] <= locked;
										match_cnt[i] <= '0;
									end else begin
										match_cnt[i] <= match_cnt[i] + 1'b1;
									end
								end else begin
									bitslip[i] <= 1'b1; // try the next rotation
									state[i] <= settle;
									match_cnt[i] <= '0; // run broken
									settle_cnt[i] <= '0;
								end
							end
							settle: begin
								// words here may still come from the old offset
								if (settle_cnt[i] == settle_cnt_width'(slip_settle_words - 1)) begin
									state[i] <= hunt;
								end else begin
									settle_cnt[i] <= settle_cnt[i] + 1'b1;
								end
							end
							locked: begin
								state[i] <= locked; // sticky, no loss-of-lock check
							end
							default: begin
								state[i] <= hunt;
							end
						endcase
					end
				end
			end
		end
	end

	// status decodes straight off the state regs, so it moves with words_valid
	always_comb begin
		for (int i = 0; i < N_LANES; i++) begin
			lane_locked[i] = (state[i] == locked);
		end
	end

	assign link_up = &lane_locked;

endmodule

//--- lvds_rx.f
lvds_rx_link_pkg.sv
lvds_rx_train_pkg.sv
word_timing.sv
lane_deserializer.sv
lane_trainer.sv
lvds_rx_top.sv
lvds_rx_checker.sv
lvds_rx_tb.sv

//--- lvds_rx_checker.sv
`timescale 1ns/1ps

module lvds_rx_checker #(
	parameter int WORD_WIDTH = lvds_rx_link_pkg::word_width_default,
	parameter int N_LANES = lvds_rx_link_pkg::n_lanes_default
) (
	input logic               bit_clock,
	input logic               arst_n,
	input logic               words_valid,
	input logic [N_LANES-1:0] lane_locked,
	input logic               link_up,
	input logic [N_LANES-1:0] bitslip // trainer to lanes inside the top
);

	// words leave at line rate, one every WORD_WIDTH bit clocks
	property word_spacing_p;
		@(posedge bit_clock) disable iff (!arst_n)
		words_valid |=> (!words_valid) [*(WORD_WIDTH - 1)] ##1 words_valid;
	endproperty

	// link_up comes up only with a word and only once every lane is locked
	property link_up_locked_p;
		@(posedge bit_clock) disable iff (!arst_n)
		$rose(link_up) |-> words_valid && (&lane_locked);
	endproperty

	// a locked lane keeps its offset
	property no_slip_when_locked_p;
		@(posedge bit_clock) disable iff (!arst_n)
		(bitslip & lane_locked) == '0;
	endproperty

	assert property (word_spacing_p)
		else $error("words_valid spacing differs from %0d bit clocks", WORD_WIDTH);
	assert property (link_up_locked_p)
		else $error("link_up rose with words_valid %b, lane_locked %b", words_valid, lane_locked);
	assert property (no_slip_when_locked_p)
		else $error("bitslip %b hit a locked lane, lane_locked %b", bitslip, lane_locked);

endmodule

bind lvds_rx_top lvds_rx_checker #(
	.WORD_WIDTH(WORD_WIDTH),
	.N_LANES(N_LANES)
) checker_i (
	.bit_clock(bit_clock),
	.arst_n(arst_n),
	.words_valid(words_valid),
	.lane_locked(lane_locked),
	.link_up(link_up),
	.bitslip(bitslip)
);

//--- lvds_rx_link_pkg.sv
package lvds_rx_link_pkg;

	// link shape, the top level takes these as parameter defaults
	localparam int word_width_default = 10; // bits per parallel word, as on a tmds channel
	localparam int n_lanes_default = 3; // serial data lanes

	// word layout
	// bit 0 of a word is the earliest bit received on the line,
	// so a word sent lsb first comes back out in the same order
	typedef logic [word_width_default-1:0] word_t;

	// alignment pattern sent while the link trains
	// the five ones go out first (bits 4:0), then the five zeros
	// every rotation of it differs, so only one offset can match
	localparam word_t training_word = 10'b00000_11111;

	// the words bus carries the lanes side by side
	// lane 0 sits in the low word_width bits, lane 1 next, and so on

endpackage

//--- lvds_rx_tb.sv
`timescale 1ns/1ps

module lvds_rx_tb;

	import lvds_rx_link_pkg::*;
	import lvds_rx_train_pkg::*;

	localparam int WORD_WIDTH = word_width_default;
	localparam int N_LANES = n_lanes_default;
	localparam int payload_per_run = 200;
	localparam int train_words = WORD_WIDTH * (WORD_WIDTH + slip_settle_words + 1) + lock_matches;
	localparam int train_timeout = train_words * WORD_WIDTH; // in bit clocks

	logic bit_clock;
	logic arst_n;
	logic [N_LANES-1:0] serial_in;
	logic retrain;
	logic [N_LANES*WORD_WIDTH-1:0] words;
	logic words_valid;
	logic [N_LANES-1:0] lane_locked;
	logic link_up;

	int seed = 81;
	int errors = 0;
	int checks = 0;
	int skew [N_LANES] = '{0, 3, 7}; // bit delay per lane
	logic [WORD_WIDTH-1:0] payload [N_LANES][2*payload_per_run];
	logic [N_LANES-1:0] dead_mask = '0; // lanes stuck at zero
	int tx_end = 0; // payload while tx_idx < tx_end, training word otherwise
	int tx_idx [N_LANES] = '{default: 0};
	int tx_pos = 0; // bit position in the word being sent
	logic [WORD_WIDTH-1:0] tx_word [N_LANES] = '{default: training_word};
	logic [15:0] skew_line [N_LANES] = '{default: '0}; // bit 0 newest
	logic compare_on = 1'b0;
	int rx_idx [N_LANES] = '{default: 0}; // next payload index expected per lane
	int rx_end = 0;
	logic [N_LANES-1:0] rx_started = '0; // lane is past its training words
	int gap = -1; // bit clocks since the last words_valid
	logic [N_LANES-1:0] locked_prev = '0; // lane_locked at the previous falling edge
	logic link_prev = 1'b0; // link_up at the previous falling edge

	lvds_rx_top #(
		.WORD_WIDTH(WORD_WIDTH),
		.N_LANES(N_LANES)
	) dut_i (
		.bit_clock(bit_clock),
		.arst_n(arst_n),
		.serial_in(serial_in),
		.retrain(retrain),
		.words(words),
		.words_valid(words_valid),
		.lane_locked(lane_locked),
		.link_up(link_up)
	);

	initial begin
		bit_clock = 1'b0;
		forever #5 bit_clock = ~bit_clock;
	end

	// the index-th payload word sent on a lane
	function automatic logic [WORD_WIDTH-1:0] expected_word(input int lane, input int index);
		return payload[lane][index];
	endfunction

	function automatic bit payload_done();
		for (int l = 0; l < N_LANES; l++) begin
			if (rx_idx[l] < rx_end) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got 'h%0h, expected 'h%0h", $time, name, got, exp);
		end
	endtask

	// serial feed sends each word lsb first and delays it by the lane skew
	always @(posedge bit_clock) begin
		#1;
		for (int l = 0; l < N_LANES; l++) begin
			if (tx_pos == 0) begin
				if (tx_idx[l] < tx_end) begin
					tx_word[l] = payload[l][tx_idx[l]];
					tx_idx[l]++;
				end else begin
					tx_word[l] = training_word;
				end
			end
			skew_line[l] = {skew_line[l][14:0], tx_word[l][tx_pos] & ~dead_mask[l]};
			serial_in[l] = skew_line[l][skew[l]]; // seen skew bits later
		end
		tx_pos = (tx_pos == WORD_WIDTH - 1) ? 0 : tx_pos + 1;
	end

	// compare side samples at the falling edge where outputs are stable
	always @(negedge bit_clock) begin
		if (!arst_n) begin
			gap = -1;
			locked_prev = lane_locked;
			link_prev = link_up;
		end else begin
			if (gap >= 0) begin
				gap++;
			end
			if (words_valid) begin
				if (gap >= 0) begin
					check_value("words_valid spacing", gap, WORD_WIDTH);
				end
				gap = 0;
			end
			// lock status only moves together with a word
			if (!words_valid &&
					(lane_locked !== locked_prev || link_up !== link_prev)) begin
				errors++;
				$display("lock status changed without words_valid at %0t", $time);
			end
			locked_prev = lane_locked;
			link_prev = link_up;
			if ((dut_i.bitslip & lane_locked) != '0) begin
				errors++;
				$display("a locked lane was sent a bitslip at %0t", $time);
			end
			if (words_valid && compare_on) begin
				for (int l = 0; l < N_LANES; l++) begin
					// leading training words are skipped per lane
					if (rx_idx[l] < rx_end && (rx_started[l] ||
							words[l*WORD_WIDTH +: WORD_WIDTH] != training_word)) begin
						rx_started[l] = 1'b1;
						check_value($sformatf("words[lane %0d]", l),
							words[l*WORD_WIDTH +: WORD_WIDTH], expected_word(l, rx_idx[l]));
						rx_idx[l]++;
					end
				end
			end
		end
	end

	task automatic fill_payload();
		logic [31:0] r;
		for (int l = 0; l < N_LANES; l++) begin
			for (int i = 0; i < 2*payload_per_run; i++) begin
				do begin
					r = $random(seed);
				end while (r[WORD_WIDTH-1:0] == training_word); // no fake alignment
				payload[l][i] = r[WORD_WIDTH-1:0];
			end
		end
	endtask

	task automatic apply_reset();
		@(posedge bit_clock);
		#1 arst_n = 1'b0;
		repeat (5) begin
			@(negedge bit_clock);
			check_value("words_valid", words_valid, 0);
			check_value("lane_locked", lane_locked, 0);
			check_value("link_up", link_up, 0);
			@(posedge bit_clock);
		end
		#1 arst_n = 1'b1;
	endtask

	task automatic wait_word_valid(input string what);
		int n;
		n = 0;
		do begin
			@(negedge bit_clock);
			n++;
		end while (!words_valid && n < 2*WORD_WIDTH);
		if (!words_valid) begin
			errors++;
			$display("timeout: no words_valid while waiting for %s", what);
		end
	endtask

	task automatic wait_link_up(input string what);
		int n;
		n = 0;
		while (!link_up && n < train_timeout) begin
			@(negedge bit_clock);
			n++;
		end
		if (!link_up) begin
			errors++;
			$display("timeout: link did not come up during %s", what);
		end
	endtask

	task automatic run_payload(input int first, input int last);
		int n;
		for (int l = 0; l < N_LANES; l++) begin
			rx_idx[l] = first;
		end
		rx_started = '0;
		rx_end = last;
		compare_on = 1'b1;
		tx_end = last; // lanes leave training at the next word boundary
		n = 0;
		while (!payload_done() && n < (last - first + 2*WORD_WIDTH) * WORD_WIDTH) begin
			@(negedge bit_clock);
			n++;
		end
		if (!payload_done()) begin
			errors++;
			$display("timeout: not all payload words arrived");
		end
		compare_on = 1'b0;
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	initial begin
		int err_start;
		int n;
		logic seen_up;
		arst_n = 1'b0;
		retrain = 1'b0;
		serial_in = '0;
		fill_payload();

		err_start = errors;
		apply_reset();
		n = 0;
		do begin
			@(posedge bit_clock);
			n++;
			@(negedge bit_clock);
		end while (!words_valid && n < 4*WORD_WIDTH);
		check_value("first words_valid delay", n, WORD_WIDTH + 2); // strobe plus two registers
		check_value("lane_locked", lane_locked, 0);
		check_value("link_up", link_up, 0);
		finish_test("reset", err_start);

		err_start = errors;
		wait_link_up("initial training");
		check_value("lane_locked", lane_locked, {N_LANES{1'b1}});
		repeat (lock_matches) begin
			wait_word_valid("trained words");
			for (int l = 0; l < N_LANES; l++) begin
				check_value($sformatf("words[lane %0d]", l),
					words[l*WORD_WIDTH +: WORD_WIDTH], training_word);
			end
		end
		finish_test("training", err_start);

		err_start = errors;
		run_payload(0, payload_per_run);
		finish_test("payload", err_start);

		// lanes are back on training words once the payload runs out
		err_start = errors;
		@(posedge bit_clock);
		#1 retrain = 1'b1;
		@(posedge bit_clock);
		#1 retrain = 1'b0;
		wait_word_valid("retrain");
		check_value("lane_locked", lane_locked, 0);
		check_value("link_up", link_up, 0);
		wait_link_up("retraining");
		run_payload(payload_per_run, 2*payload_per_run);
		finish_test("retrain", err_start);

		err_start = errors;
		dead_mask[N_LANES-1] = 1'b1; // last lane goes quiet
		apply_reset();
		seen_up = 1'b0;
		for (n = 0; n < train_timeout; n++) begin
			@(negedge bit_clock);
			if (link_up) begin
				seen_up = 1'b1;
			end
		end
		check_value("link_up seen", seen_up, 0);
		check_value("lane_locked", lane_locked, {1'b0, {(N_LANES-1){1'b1}}});
		finish_test("dead lane", err_start);

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- lvds_rx_top.sv
`timescale 1ns/1ps

module lvds_rx_top #(
	parameter int WORD_WIDTH = lvds_rx_link_pkg::word_width_default,
	parameter int N_LANES = lvds_rx_link_pkg::n_lanes_default
) (
	input  logic                          bit_clock,
	input  logic                          arst_n,
	input  logic [N_LANES-1:0]            serial_in,   // one serial stream per lane
	input  logic                          retrain,
	output logic [N_LANES*WORD_WIDTH-1:0] words,       // lane 0 in the low bits
	output logic                          words_valid, // 2 cycles after the strobe edge
	output logic [N_LANES-1:0]            lane_locked,
	output logic                          link_up
);

	logic word_strobe; // shared word boundary
	logic [N_LANES*WORD_WIDTH-1:0] lane_words;
	logic [N_LANES-1:0] lane_valid;
	logic [N_LANES-1:0] bitslip; // trainer back to the lanes

	// framing for all lanes
	word_timing #(
		.WORD_WIDTH(WORD_WIDTH)
	) timing_i (
		.bit_clock(bit_clock),
		.arst_n(arst_n),
		.word_strobe(word_strobe)
	);

	for (genvar i = 0; i < N_LANES; i++) begin : g_lane
		lane_deserializer #(
			.WORD_WIDTH(WORD_WIDTH)
		) lane_i (
			.bit_clock(bit_clock),
			.arst_n(arst_n),
			.serial_in(serial_in[i]),
			.word_strobe(word_strobe),
			.bitslip(bitslip[i]),
			.lane_word(lane_words[i*WORD_WIDTH +: WORD_WIDTH]),
			.lane_valid(lane_valid[i])
		);
	end

	// alignment and output register
	lane_trainer #(
		.WORD_WIDTH(WORD_WIDTH),
		.N_LANES(N_LANES)
	) trainer_i (
		.bit_clock(bit_clock),
		.arst_n(arst_n),
		.lane_words(lane_words),
		.lane_valid(lane_valid),
		.retrain(retrain),
		.bitslip(bitslip),
		.words(words),
		.words_valid(words_valid),
		.lane_locked(lane_locked),
		.link_up(link_up)
	);

endmodule

//--- lvds_rx_train_pkg.sv
package lvds_rx_train_pkg;

	// per-lane trainer state
	typedef enum logic [1:0] {
		hunt,   // look for the training word, slip on a miss
		settle, // drop words while the new offset takes hold
		locked  // sticky until retrain
	} train_state_t;

	// training timing, counted in words
	localparam int slip_settle_words = 1; // words ignored after each bitslip
	localparam int lock_matches = 4; // matches in a row to call a lane locked

	// counter widths, sized so the terminal value always fits
	localparam int match_cnt_width = $clog2(lock_matches + 1);
	localparam int settle_cnt_width = $clog2(slip_settle_words + 1);

endpackage

//--- word_timing.sv
`timescale 1ns/1ps

module word_timing #(
	parameter int WORD_WIDTH = lvds_rx_link_pkg::word_width_default
) (
	input  logic bit_clock,
	input  logic arst_n,
	output logic word_strobe // one cycle high every WORD_WIDTH bit clocks
);

	localparam int cnt_width = (WORD_WIDTH > 1) ? $clog2(WORD_WIDTH) : 1;

	logic [cnt_width-1:0] bit_cnt; // position within the current word

	// modulo counter, the strobe is registered off its last count
	// after reset release bit_cnt reaches WORD_WIDTH-1 on edge WORD_WIDTH-1,
	// so the first strobe shows up WORD_WIDTH cycles after release
	always_ff @(posedge bit_clock or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= '0;
			word_strobe <= 1'b0;
		end else begin
			if (bit_cnt == cnt_width'(WORD_WIDTH - 1)) begin
				bit_cnt <= '0; // wrap
				word_strobe <= 1'b1; // frame boundary for every lane
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
				word_strobe <= 1'b0;
			end
		end
	end

endmodule
